// ==== common/uart_defines.svh ====
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

`default_nettype none

// Clock cycles per serial bit
// Small value keeps simulation short
`define UART_CLKS_PER_BIT 8

// Width of the byte address decoded by the UART
`define UART_ADDR_BITS 4

`default_nettype wire

`endif

// ==== common/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // Bus side of the peripheral
    typedef logic [31:0] bus_word_t;
    typedef logic [3:0]  bus_strb_t;

    // Serial payload
    typedef logic [7:0] uart_byte_t;

    // Register select taken from the word address
    typedef enum logic {
        REG_DATA   = 1'b0,
        REG_STATUS = 1'b1
    } uart_reg_e;

    // Sits in the low bits of the status read word
    typedef struct packed {
        logic frame_error;
        logic overrun;
        logic rx_full;
        logic tx_busy;
    } uart_status_t;

endpackage

`default_nettype wire

// ==== uart/uart_tx.sv ====
`include "uart_defines.svh"

`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       tx_start,
    input  uart_byte_t tx_data,
    output logic       tx_busy,
    output logic       uart_tx
);

    localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
    localparam int CNT_BITS = $clog2(CLKS_PER_BIT);
    localparam int FRAME_BITS = 10;

    // Stop, data and start bits, start bit in the low position
    logic [FRAME_BITS-1:0] shift_reg;
    logic [3:0]            bit_cnt;
    logic [CNT_BITS-1:0]   cyc_cnt;
    logic                  bit_end;

    assign bit_end = (cyc_cnt == CNT_BITS'(CLKS_PER_BIT - 1));

    always_ff @(posedge clock) begin
        if (!reset) begin
            shift_reg <= '1;
            bit_cnt   <= '0;
            cyc_cnt   <= '0;
            tx_busy   <= 1'b0;
        end else if (tx_busy) begin
            if (bit_end) begin
                cyc_cnt   <= '0;
                // Ones fill in behind so the line idles high afterwards
                shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};
                if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                    bit_cnt <= '0;
                    tx_busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end else if (tx_start) begin
            shift_reg <= {1'b1, tx_data, 1'b0};
            bit_cnt   <= '0;
            cyc_cnt   <= '0;
            tx_busy   <= 1'b1;
        end
    end

    assign uart_tx = shift_reg[0];

    // Bus port must hold off new bytes until the frame is out
    tx_start_when_idle: assert property (
        @(posedge clock) disable iff (!reset)
        tx_start |-> !tx_busy
    );

    // Whole frame has shifted out by the time busy drops
    line_high_when_idle: assert property (
        @(posedge clock) disable iff (!reset)
        !tx_busy |-> uart_tx
    );

endmodule

`default_nettype wire

// ==== uart/uart_rx.sv ====
`include "uart_defines.svh"

`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       uart_rx,
    output logic       rx_valid,
    output uart_byte_t rx_data,
    output logic       rx_frame_error
);

    localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
    localparam int HALF_BIT = CLKS_PER_BIT / 2;
    localparam int CNT_BITS = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e           state;
    logic [1:0]          sync_q;
    logic                rx_line;
    logic                rx_prev;
    logic                fall;
    logic [2:0]          bit_cnt;
    logic [CNT_BITS-1:0] cyc_cnt;
    logic                half_end;
    logic                bit_end;
    uart_byte_t          data_shift;

    assign rx_line  = sync_q[1];
    assign fall     = rx_prev && !rx_line;
    assign half_end = (cyc_cnt == CNT_BITS'(HALF_BIT - 1));
    assign bit_end  = (cyc_cnt == CNT_BITS'(CLKS_PER_BIT - 1));

    // Two flop synchronizer, plus one more flop for edge detection
    always_ff @(posedge clock) begin
        if (!reset) begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync_q  <= {sync_q[0], uart_rx};
            rx_prev <= rx_line;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state          <= RX_IDLE;
            bit_cnt        <= '0;
            cyc_cnt        <= '0;
            rx_valid       <= 1'b0;
            rx_frame_error <= 1'b0;
        end else begin
            rx_valid       <= 1'b0;
            rx_frame_error <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cyc_cnt <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        // High again at mid start bit means a glitch
                        state   <= rx_line ? RX_IDLE : RX_DATA;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cyc_cnt <= '0;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cyc_cnt        <= '0;
                        rx_valid       <= rx_line;
                        rx_frame_error <= !rx_line;
                        state          <= RX_IDLE;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clock) begin
        if (state == RX_DATA && bit_end) begin
            data_shift <= {rx_line, data_shift[7:1]};
        end
    end

    assign rx_data = data_shift;

    valid_or_error: assert property (
        @(posedge clock) disable iff (!reset)
        !(rx_valid && rx_frame_error)
    );

endmodule

`default_nettype wire

// ==== uart/uart_bus_port.sv ====
`include "uart_defines.svh"

`default_nettype none

module uart_bus_port
    import uart_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       mem_valid,
    input  logic [`UART_ADDR_BITS-1:0] mem_addr,
    input  bus_word_t                  mem_wdata,
    input  bus_strb_t                  mem_wstrb,
    output bus_word_t                  mem_rdata,
    output logic                       mem_ready,
    output logic                       tx_start,
    output uart_byte_t                 tx_data,
    input  logic                       tx_busy,
    input  logic                       rx_valid,
    input  uart_byte_t                 rx_data,
    input  logic                       rx_frame_error
);

    localparam int ADDR_BITS = `UART_ADDR_BITS;
    localparam int STATUS_PAD = $bits(bus_word_t) - $bits(uart_status_t);
    localparam int BYTE_PAD = $bits(bus_word_t) - $bits(uart_byte_t);

    uart_reg_e    reg_sel;
    logic         is_write;
    logic         done;
    logic         pending;
    logic         do_status_rd;
    logic         do_status_wr;
    logic         do_data_rd;
    logic         do_data_wr;
    logic         accept;
    logic         rx_full_q;
    logic         overrun_q;
    logic         frame_error_q;
    uart_byte_t   rx_buf;
    uart_status_t status;

    // Word index 1 is the status register
    assign reg_sel  = (mem_addr[ADDR_BITS-1:2] == (ADDR_BITS - 2)'(1)) ? REG_STATUS : REG_DATA;
    assign is_write = |mem_wstrb;
    assign pending  = mem_valid && !done;

    assign do_status_rd = pending && !is_write && (reg_sel == REG_STATUS);
    assign do_status_wr = pending && is_write && (reg_sel == REG_STATUS);
    // Data accesses stall until the buffer or the transmitter is ready
    assign do_data_rd   = pending && !is_write && (reg_sel == REG_DATA) && rx_full_q;
    assign do_data_wr   = pending && is_write && (reg_sel == REG_DATA) && !tx_busy;
    assign accept       = do_status_rd || do_status_wr || do_data_rd || do_data_wr;

    assign status = '{
        frame_error: frame_error_q,
        overrun:     overrun_q,
        rx_full:     rx_full_q,
        tx_busy:     tx_busy
    };

    always_ff @(posedge clock) begin
        if (!reset) begin
            mem_ready     <= 1'b0;
            tx_start      <= 1'b0;
            done          <= 1'b0;
            rx_full_q     <= 1'b0;
            overrun_q     <= 1'b0;
            frame_error_q <= 1'b0;
        end else begin
            mem_ready <= accept;
            tx_start  <= do_data_wr;
            // Served request stays blocked until the requester drops valid
            if (accept) begin
                done <= 1'b1;
            end else if (!mem_valid) begin
                done <= 1'b0;
            end
            if (do_status_rd) begin
                overrun_q     <= 1'b0;
                frame_error_q <= 1'b0;
            end
            // New events win over the clear of a status read
            if (rx_valid) begin
                if (rx_full_q && !do_data_rd) begin
                    overrun_q <= 1'b1;
                end else begin
                    rx_full_q <= 1'b1;
                end
            end else if (do_data_rd) begin
                rx_full_q <= 1'b0;
            end
            if (rx_frame_error) begin
                frame_error_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_data_wr) begin
            tx_data <= mem_wdata[7:0];
        end
        // Full buffer keeps the old byte
        if (rx_valid && (!rx_full_q || do_data_rd)) begin
            rx_buf <= rx_data;
        end
        if (do_status_rd) begin
            mem_rdata <= {{STATUS_PAD{1'b0}}, status};
        end else if (do_data_rd) begin
            mem_rdata <= {{BYTE_PAD{1'b0}}, rx_buf};
        end else begin
            mem_rdata <= '0;
        end
    end

    ready_is_pulse: assert property (
        @(posedge clock) disable iff (!reset)
        mem_ready |=> !mem_ready
    );

endmodule

`default_nettype wire

// ==== design/uart_top.sv ====
`include "uart_defines.svh"

`default_nettype none

module uart_top
    import uart_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       mem_valid,
    input  logic [`UART_ADDR_BITS-1:0] mem_addr,
    input  bus_word_t                  mem_wdata,
    input  bus_strb_t                  mem_wstrb,
    output bus_word_t                  mem_rdata,
    output logic                       mem_ready,
    input  logic                       uart_rx,
    output logic                       uart_tx
);

    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_busy;
    logic       rx_valid;
    uart_byte_t rx_data;
    logic       rx_frame_error;

    uart_bus_port u_bus_port (
        .clock          (clock),
        .reset          (reset),
        .mem_valid      (mem_valid),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_wstrb      (mem_wstrb),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready),
        .tx_start       (tx_start),
        .tx_data        (tx_data),
        .tx_busy        (tx_busy),
        .rx_valid       (rx_valid),
        .rx_data        (rx_data),
        .rx_frame_error (rx_frame_error)
    );

    uart_tx u_tx (
        .clock    (clock),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .uart_tx  (uart_tx)
    );

    uart_rx u_rx (
        .clock          (clock),
        .reset          (reset),
        .uart_rx        (uart_rx),
        .rx_valid       (rx_valid),
        .rx_data        (rx_data),
        .rx_frame_error (rx_frame_error)
    );

endmodule

`default_nettype wire

// ==== dv/uart_tb.sv ====
`include "uart_defines.svh"

`default_nettype none

module uart_tb
    import uart_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
    localparam int N_ENTRIES = 19;
    localparam int TIMEOUT_CYCLES = N_ENTRIES * (12 * CLKS_PER_BIT + 20);
    localparam logic [`UART_ADDR_BITS-1:0] DATA_ADDR = 'h0;
    localparam logic [`UART_ADDR_BITS-1:0] STATUS_ADDR = 'h4;

    typedef enum logic [2:0] {
        WRITE_BYTE,
        INJECT_BYTE,
        INJECT_BAD_STOP,
        READ_DATA,
        READ_STATUS
    } step_kind_e;

    typedef struct packed {
        step_kind_e   kind;
        uart_byte_t   value;
        uart_byte_t   exp_byte;
        uart_status_t exp_status;
        logic         inject_during;
    } step_t;

    logic                       clock = 1'b0;
    logic                       reset;
    logic                       mem_valid;
    logic [`UART_ADDR_BITS-1:0] mem_addr;
    bus_word_t                  mem_wdata;
    bus_strb_t                  mem_wstrb;
    bus_word_t                  mem_rdata;
    logic                       mem_ready;
    logic                       uart_rx;
    logic                       uart_tx;

    integer      seed = 32'h27f1_1389;
    int unsigned cycle_count = 0;
    step_t       steps [N_ENTRIES];
    int          n_steps = 0;
    bus_word_t   read_word;
    uart_byte_t  tx_seen[$];
    uart_byte_t  tx_expected[$];

    uart_top dut0 (
        .clock     (clock),
        .reset     (reset),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .uart_rx   (uart_rx),
        .uart_tx   (uart_tx)
    );

    always #2 clock = ~clock;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "Run stopped after a failure");
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_count);
            abort_run();
        end
    end

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input uart_status_t got,
                                input uart_status_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic uart_status_t make_status(input logic frame_error, input logic overrun,
                                                 input logic rx_full, input logic tx_busy);
        uart_status_t s;
        s.frame_error = frame_error;
        s.overrun     = overrun;
        s.rx_full     = rx_full;
        s.tx_busy     = tx_busy;
        return s;
    endfunction

    task automatic add_step(input step_kind_e kind, input uart_byte_t value,
                            input uart_byte_t exp_byte, input uart_status_t exp_status,
                            input logic inject_during);
        steps[n_steps] = '{kind, value, exp_byte, exp_status, inject_during};
        n_steps = n_steps + 1;
    endtask

    // One request, held until the ready pulse, dropped in the following cycle
    task automatic bus_access(input logic [`UART_ADDR_BITS-1:0] addr, input bus_word_t wdata,
                              input bus_strb_t wstrb);
        @(posedge clock);
        #1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = wstrb;
        mem_valid = 1'b1;
        do begin
            @(posedge clock);
            #1;
        end while (mem_ready !== 1'b1);
        read_word = mem_rdata;
        @(posedge clock);
        #1;
        mem_valid = 1'b0;
        mem_wstrb = '0;
    endtask

    task automatic hold_rx_bit(input logic b);
        uart_rx = b;
        repeat (CLKS_PER_BIT) @(posedge clock);
        #1;
    endtask

    // 8N1 frame on uart_rx followed by one idle bit
    task automatic drive_serial(input uart_byte_t value, input logic stop_bit);
        @(posedge clock);
        #1;
        hold_rx_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            hold_rx_bit(value[i]);
        end
        hold_rx_bit(stop_bit);
        hold_rx_bit(1'b1);
    endtask

    // Decode frames on uart_tx by sampling at mid bit
    initial begin
        uart_byte_t frame;
        @(posedge reset);
        forever begin
            @(negedge uart_tx);
            repeat (CLKS_PER_BIT / 2) @(posedge clock);
            #1;
            check_line("uart_tx start bit", uart_tx, 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clock);
                #1;
                frame[i] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(posedge clock);
            #1;
            check_line("uart_tx stop bit", uart_tx, 1'b1);
            tx_seen.push_back(frame);
        end
    end

    task automatic apply_step(input step_t s);
        case (s.kind)
            WRITE_BYTE: begin
                bus_access(DATA_ADDR, {24'h0, s.value}, 4'b0001);
                tx_expected.push_back(s.value);
            end
            INJECT_BYTE: drive_serial(s.value, 1'b1);
            INJECT_BAD_STOP: drive_serial(s.value, 1'b0);
            READ_DATA: begin
                if (s.inject_during) begin
                    fork
                        bus_access(DATA_ADDR, '0, '0);
                        begin
                            repeat (4) @(posedge clock);
                            drive_serial(s.value, 1'b1);
                        end
                    join
                end else begin
                    bus_access(DATA_ADDR, '0, '0);
                end
                check_byte("mem_rdata", read_word[7:0], s.exp_byte);
            end
            READ_STATUS: begin
                bus_access(STATUS_ADDR, '0, '0);
                check_status("status", read_word[3:0], s.exp_status);
            end
            default: begin
                $display("Stimulus table holds a step of unknown kind");
                abort_run();
            end
        endcase
    endtask

    initial begin
        uart_byte_t a;
        uart_byte_t b;
        uart_byte_t c;
        uart_byte_t d;
        uart_byte_t e;
        uart_byte_t f;
        uart_byte_t g;
        reset     = 1'b0;
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        uart_rx   = 1'b1;

        a = 8'($random(seed));
        b = 8'($random(seed));
        c = 8'($random(seed));
        d = 8'($random(seed));
        e = 8'($random(seed));
        f = 8'($random(seed));
        g = 8'($random(seed));

        add_step(READ_STATUS, 8'h00, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        add_step(WRITE_BYTE, a, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        add_step(READ_STATUS, 8'h00, 8'h00, make_status(0, 0, 0, 1), 1'b0);
        add_step(WRITE_BYTE, b, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        add_step(READ_STATUS, 8'h00, 8'h00, make_status(0, 0, 0, 1), 1'b0);
        add_step(INJECT_BYTE, c, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        add_step(READ_STATUS, 8'h00, 8'h00, make_status(0, 0, 1, 0), 1'b0);
        add_step(READ_DATA, 8'h00, c, make_status(0, 0, 0, 0), 1'b0);
        add_step(READ_STATUS, 8'h00, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        // Second byte arrives while the first is still held
        add_step(INJECT_BYTE, d, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        add_step(INJECT_BYTE, e, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        add_step(READ_STATUS, 8'h00, 8'h00, make_status(0, 1, 1, 0), 1'b0);
        add_step(READ_DATA, 8'h00, d, make_status(0, 0, 0, 0), 1'b0);
        add_step(READ_STATUS, 8'h00, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        add_step(INJECT_BAD_STOP, f, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        add_step(READ_STATUS, 8'h00, 8'h00, make_status(1, 0, 0, 0), 1'b0);
        add_step(READ_STATUS, 8'h00, 8'h00, make_status(0, 0, 0, 0), 1'b0);
        add_step(READ_DATA, g, g, make_status(0, 0, 0, 0), 1'b1);
        add_step(READ_STATUS, 8'h00, 8'h00, make_status(0, 0, 0, 0), 1'b0);

        repeat (8) @(posedge clock);
        #1;
        reset = 1'b1;
        @(posedge clock);
        #1;
        check_line("uart_tx", uart_tx, 1'b1);

        for (int i = 0; i < n_steps; i++) begin
            apply_step(steps[i]);
        end

        while (tx_seen.size() < tx_expected.size()) begin
            @(posedge clock);
        end
        if (tx_seen.size() != tx_expected.size()) begin
            $display("Monitor decoded %0d frames but %0d bytes were written",
                     tx_seen.size(), tx_expected.size());
            abort_run();
        end
        foreach (tx_expected[i]) begin
            check_byte("uart_tx frame", tx_seen[i], tx_expected[i]);
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_bus_port.sv
design/uart_top.sv
dv/uart_tb.sv

// ==== Makefile ====
TOP = uart_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sim.f --top-module $(TOP) -Mdir obj_dir -o sim_uart

run: compile
	@out="$$(./obj_dir/sim_uart)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
